//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module i2c_master_tb -Mdir obj_dir
	./obj_dir/Vi2c_master_tb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/i2c_bit_engine.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire                   tick,
    input  wire                   sym_start,
    input  wire i2c_pkg::bit_op_t sym_op,
    input  wire                   bit_value,
    input  wire                   scl_in,
    input  wire                   sda_in,
    output logic                  sym_done,
    output logic                  sampled_bit,
    output logic                  scl_low,
    output logic                  sda_low
);

    import i2c_pkg::*;

    logic    active;
    phase_t  phase;
    bit_op_t op_q;

    // every symbol: SDA set up while SCL is low, then
    // phase 0 releases SCL, phase 1 waits for SCL high,
    // phase 2 acts during SCL high, phase 3 finishes
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            active   <= 1'b0;
            phase    <= '0;
            sym_done <= 1'b0;
            scl_low  <= 1'b0;
            sda_low  <= 1'b0;
        end else begin
            sym_done <= 1'b0;
            if (!active) begin
                if (sym_start) begin
                    active <= 1'b1;
                    phase  <= '0;
                    case (sym_op)
                        op_stop:  sda_low <= 1'b1;
                        op_write: sda_low <= ~bit_value;
                        default:  sda_low <= 1'b0;
                    endcase
                end
            end else if (tick) begin
                // slave may hold SCL low here
                if (phase != phase_t'(1) || scl_in) begin
                    phase <= phase + phase_t'(1);
                end
                case (phase)
                    phase_t'(0): begin
                        scl_low <= 1'b0;
                    end
                    phase_t'(2): begin
                        case (op_q)
                            op_start, op_restart: sda_low <= 1'b1;
                            op_stop:              sda_low <= 1'b0;
                            default:              scl_low <= 1'b1;
                        endcase
                    end
                    phase_t'(3): begin
                        if (op_q == op_start || op_q == op_restart) begin
                            scl_low <= 1'b1;
                        end
                        active   <= 1'b0;
                        sym_done <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!active && sym_start) begin
            op_q <= sym_op;
        end
        // end of SCL high, just before it is pulled low
        if (active && tick && phase == phase_t'(2)) begin
            sampled_bit <= sda_in;
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_byte_engine.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_engine (
    input  wire                  clock,
    input  wire                  reset_n,
    input  wire                  byte_start,
    input  wire                  byte_write,
    input  wire i2c_pkg::byte_t  tx_byte,
    input  wire                  send_nack,
    input  wire                  sym_done,
    input  wire                  sampled_bit,
    output logic                 bit_start,
    output i2c_pkg::bit_op_t     bit_op,
    output logic                 bit_value,
    output logic                 byte_done,
    output i2c_pkg::byte_t       rx_byte,
    output logic                 ack_received
);

    import i2c_pkg::*;

    logic       active;
    logic       writing;
    logic       nack_q;
    bit_count_t bit_count;
    byte_t      shift;

    // data bits while count is nonzero, then the acknowledge slot
    always_comb begin
        if (bit_count != '0) begin
            bit_op    = writing ? op_write : op_read;
            bit_value = shift[bits_per_byte-1];
        end else begin
            bit_op    = writing ? op_read : op_write;
            bit_value = nack_q;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            active       <= 1'b0;
            bit_count    <= '0;
            bit_start    <= 1'b0;
            byte_done    <= 1'b0;
            ack_received <= 1'b0;
        end else begin
            bit_start <= 1'b0;
            byte_done <= 1'b0;
            if (!active) begin
                if (byte_start) begin
                    active    <= 1'b1;
                    bit_count <= bit_count_t'(bits_per_byte);
                    bit_start <= 1'b1;
                end
            end else if (sym_done) begin
                if (bit_count != '0) begin
                    bit_count <= bit_count - bit_count_t'(1);
                    bit_start <= 1'b1;
                end else begin
                    active       <= 1'b0;
                    byte_done    <= 1'b1;
                    // low on the ninth bit means acknowledged
                    ack_received <= ~sampled_bit;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!active && byte_start) begin
            shift   <= tx_byte;
            writing <= byte_write;
            nack_q  <= send_nack;
        end else if (active && sym_done && bit_count != '0) begin
            shift <= {shift[bits_per_byte-2:0], sampled_bit};
        end
        if (active && sym_done && bit_count == '0) begin
            rx_byte <= shift;
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_master.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master (
    input  wire                     clock,
    input  wire                     reset_n,
    input  wire                     start,
    input  wire                     read_write,
    input  wire i2c_pkg::dev_addr_t device_address,
    input  wire i2c_pkg::byte_t     register_address,
    input  wire i2c_pkg::byte_t     write_data,
    input  wire i2c_pkg::divider_t  divider,
    output i2c_pkg::byte_t          read_data,
    output logic                    busy,
    output logic                    done,
    output logic                    ack_error,
    inout  wire                     sda,
    inout  wire                     scl
);

    import i2c_pkg::*;

    logic    tick;
    logic    byte_start;
    logic    byte_write;
    byte_t   tx_byte;
    logic    send_nack;
    logic    byte_done;
    byte_t   rx_byte;
    logic    ack_received;
    logic    seq_sym_start;
    bit_op_t seq_sym_op;
    logic    bit_start;
    bit_op_t bit_op;
    logic    bit_value;
    logic    sym_start;
    bit_op_t sym_op;
    logic    sym_done;
    logic    sampled_bit;
    logic    scl_low;
    logic    sda_low;

    // open drain, pull-ups are external
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

    // sequencer and byte engine never request at once
    assign sym_start = seq_sym_start | bit_start;
    assign sym_op    = bit_start ? bit_op : seq_sym_op;

    i2c_tick_divider u_tick_divider (
        .clock   (clock),
        .reset_n (reset_n),
        .divider (divider),
        .tick    (tick)
    );

    i2c_bit_engine u_bit_engine (
        .clock       (clock),
        .reset_n     (reset_n),
        .tick        (tick),
        .sym_start   (sym_start),
        .sym_op      (sym_op),
        .bit_value   (bit_value),
        .scl_in      (scl),
        .sda_in      (sda),
        .sym_done    (sym_done),
        .sampled_bit (sampled_bit),
        .scl_low     (scl_low),
        .sda_low     (sda_low)
    );

    i2c_byte_engine u_byte_engine (
        .clock        (clock),
        .reset_n      (reset_n),
        .byte_start   (byte_start),
        .byte_write   (byte_write),
        .tx_byte      (tx_byte),
        .send_nack    (send_nack),
        .sym_done     (sym_done),
        .sampled_bit  (sampled_bit),
        .bit_start    (bit_start),
        .bit_op       (bit_op),
        .bit_value    (bit_value),
        .byte_done    (byte_done),
        .rx_byte      (rx_byte),
        .ack_received (ack_received)
    );

    i2c_transaction_sequencer u_sequencer (
        .clock            (clock),
        .reset_n          (reset_n),
        .start            (start),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .byte_done        (byte_done),
        .rx_byte          (rx_byte),
        .ack_received     (ack_received),
        .sym_done         (sym_done),
        .byte_start       (byte_start),
        .byte_write       (byte_write),
        .tx_byte          (tx_byte),
        .send_nack        (send_nack),
        .sym_start        (seq_sym_start),
        .sym_op           (seq_sym_op),
        .busy             (busy),
        .done             (done),
        .ack_error        (ack_error),
        .read_data        (read_data)
    );

endmodule

`default_nettype wire

//--- logic/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    localparam int bits_per_byte = 8;

    // direction bit appended to the device address
    localparam logic read_bit  = 1'b1;
    localparam logic write_bit = 1'b0;

    typedef logic [6:0]               dev_addr_t;
    typedef logic [bits_per_byte-1:0] byte_t;
    typedef logic [15:0]              divider_t;
    typedef logic [1:0]               phase_t;

    // counts data bits left in a byte, 8 down to 0
    typedef logic [$clog2(bits_per_byte+1)-1:0] bit_count_t;

    typedef enum logic [2:0] {
        op_start,
        op_restart,
        op_stop,
        op_write,
        op_read
    } bit_op_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_dev_write,
        st_reg_addr,
        st_write_data,
        st_restart,
        st_dev_read,
        st_read_data,
        st_stop
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/i2c_tick_divider.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_tick_divider (
    input  wire                    clock,
    input  wire                    reset_n,
    input  wire i2c_pkg::divider_t divider,
    output logic                   tick
);

    import i2c_pkg::*;

    divider_t count;

    // one tick every divider+1 clocks
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == divider) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + divider_t'(1);
            tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_transaction_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_transaction_sequencer (
    input  wire                     clock,
    input  wire                     reset_n,
    input  wire                     start,
    input  wire                     read_write,
    input  wire i2c_pkg::dev_addr_t device_address,
    input  wire i2c_pkg::byte_t     register_address,
    input  wire i2c_pkg::byte_t     write_data,
    input  wire                     byte_done,
    input  wire i2c_pkg::byte_t     rx_byte,
    input  wire                     ack_received,
    input  wire                     sym_done,
    output logic                    byte_start,
    output logic                    byte_write,
    output i2c_pkg::byte_t          tx_byte,
    output logic                    send_nack,
    output logic                    sym_start,
    output i2c_pkg::bit_op_t        sym_op,
    output logic                    busy,
    output logic                    done,
    output logic                    ack_error,
    output i2c_pkg::byte_t          read_data
);

    import i2c_pkg::*;

    seq_state_t state;
    logic       rw_q;
    dev_addr_t  dev_q;
    byte_t      reg_q;
    byte_t      data_q;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= st_idle;
            busy       <= 1'b0;
            done       <= 1'b0;
            ack_error  <= 1'b0;
            read_data  <= '0;
            byte_start <= 1'b0;
            sym_start  <= 1'b0;
        end else begin
            byte_start <= 1'b0;
            sym_start  <= 1'b0;
            done       <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        busy      <= 1'b1;
                        ack_error <= 1'b0;
                        sym_start <= 1'b1;
                        sym_op    <= op_start;
                        state     <= st_start;
                    end
                end
                st_start: begin
                    if (sym_done) begin
                        byte_start <= 1'b1;
                        byte_write <= 1'b1;
                        send_nack  <= 1'b0;
                        tx_byte    <= {dev_q, write_bit};
                        state      <= st_dev_write;
                    end
                end
                st_dev_write: begin
                    if (byte_done && ack_received) begin
                        byte_start <= 1'b1;
                        tx_byte    <= reg_q;
                        state      <= st_reg_addr;
                    end
                end
                st_reg_addr: begin
                    if (byte_done && ack_received) begin
                        if (rw_q == read_bit) begin
                            sym_start <= 1'b1;
                            sym_op    <= op_restart;
                            state     <= st_restart;
                        end else begin
                            byte_start <= 1'b1;
                            tx_byte    <= data_q;
                            state      <= st_write_data;
                        end
                    end
                end
                st_write_data: begin
                    if (byte_done) begin
                        ack_error <= ~ack_received;
                        sym_start <= 1'b1;
                        sym_op    <= op_stop;
                        state     <= st_stop;
                    end
                end
                st_restart: begin
                    if (sym_done) begin
                        byte_start <= 1'b1;
                        tx_byte    <= {dev_q, read_bit};
                        state      <= st_dev_read;
                    end
                end
                st_dev_read: begin
                    if (byte_done && ack_received) begin
                        // single byte read, so answer it with NACK
                        byte_start <= 1'b1;
                        byte_write <= 1'b0;
                        send_nack  <= 1'b1;
                        state      <= st_read_data;
                    end
                end
                st_read_data: begin
                    if (byte_done) begin
                        read_data <= rx_byte;
                        sym_start <= 1'b1;
                        sym_op    <= op_stop;
                        state     <= st_stop;
                    end
                end
                st_stop: begin
                    if (sym_done) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
            // missing acknowledge on a sent byte goes straight to stop
            if (byte_done && !ack_received &&
                (state == st_dev_write || state == st_reg_addr || state == st_dev_read)) begin
                ack_error <= 1'b1;
                sym_start <= 1'b1;
                sym_op    <= op_stop;
                state     <= st_stop;
            end
        end
    end

    // request captured once per transaction
    always_ff @(posedge clock) begin
        if (state == st_idle && start) begin
            rw_q   <= read_write;
            dev_q  <= device_address;
            reg_q  <= register_address;
            data_q <= write_data;
        end
    end

endmodule

`default_nettype wire

//--- tests/i2c_master_checker.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_checker (
    input wire                      clock,
    input wire                      reset_n,
    input wire                      busy,
    input wire                      done,
    input wire                      scl_low,
    input wire                      sda_low,
    input wire i2c_pkg::phase_t     phase
);

    import i2c_pkg::*;

    int unsigned failures = 0;

    done_single_cycle: assert property (@(posedge clock) disable iff (!reset_n)
        done |=> !done)
        else begin
            $error("done high for two cycles");
            failures++;
        end

    done_after_busy: assert property (@(posedge clock) disable iff (!reset_n)
        done |-> $past(busy))
        else begin
            $error("done without busy in the previous cycle");
            failures++;
        end

    bus_released_when_idle: assert property (@(posedge clock) disable iff (!reset_n)
        !busy |-> (!scl_low && !sda_low))
        else begin
            $error("bus line driven low while not busy");
            failures++;
        end

    phase_idle_zero: assert property (@(posedge clock) disable iff (!reset_n)
        !busy |-> (phase == phase_t'(0)))
        else begin
            $error("bit engine phase nonzero while not busy");
            failures++;
        end

endmodule

bind i2c_master i2c_master_checker u_checker (
    .clock   (clock),
    .reset_n (reset_n),
    .busy    (busy),
    .done    (done),
    .scl_low (scl_low),
    .sda_low (sda_low),
    .phase   (u_bit_engine.phase)
);

`default_nettype wire

//--- tests/i2c_master_tb.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_tb;

    import i2c_pkg::*;

    logic        clock;
    logic        reset_n;
    logic        start;
    logic        read_write;
    dev_addr_t   device_address;
    byte_t       register_address;
    byte_t       write_data;
    divider_t    divider;
    byte_t       read_data;
    logic        busy;
    logic        done;
    logic        ack_error;
    logic [15:0] stretch_cycles;
    wire         sda;
    wire         scl;

    pullup (sda);
    pullup (scl);

    always #50 clock = ~clock;

    i2c_master DUT (
        .clock            (clock),
        .reset_n          (reset_n),
        .start            (start),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .divider          (divider),
        .read_data        (read_data),
        .busy             (busy),
        .done             (done),
        .ack_error        (ack_error),
        .sda              (sda),
        .scl              (scl)
    );

    i2c_slave_model #(.address(7'h50)) u_slave (
        .clock          (clock),
        .stretch_cycles (stretch_cycles),
        .sda            (sda),
        .scl            (scl)
    );

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("ERR time %0t %s: got %0h, expected %0h",
                                      $time, name, actual, expected));
        end
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > limit) begin
                stop_on_failure($sformatf("timeout, no done within %0d cycles", limit));
            end
        end
    endtask

    // nothing may follow a finished transaction
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_value("done", done, 0);
            check_value("busy", busy, 0);
        end
    endtask

    task automatic run_vector(input int num, input byte kind, input logic [31:0] dev,
                              input logic [31:0] reg_addr, input logic [31:0] wdata,
                              input logic [31:0] div, input logic [31:0] stretch,
                              input logic [31:0] exp_rd, input logic [31:0] exp_err);
        int limit;
        limit = 1000 + 200 * (int'(div[15:0]) + 1) + 4 * int'(stretch[15:0]);
        if (kind != "W" && kind != "R" && kind != "D") begin
            stop_on_failure($sformatf("unknown transaction kind in vector %0d", num));
        end
        @(posedge clock);
        read_write       <= (kind == "R");
        device_address   <= dev[6:0];
        register_address <= reg_addr[7:0];
        write_data       <= wdata[7:0];
        divider          <= div[15:0];
        stretch_cycles   <= stretch[15:0];
        start            <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        check_value($sformatf("busy (vector %0d)", num), busy, 1);
        if (kind == "D") begin
            // second request must be dropped
            @(posedge clock);
            write_data <= ~wdata[7:0];
            start      <= 1'b1;
            @(posedge clock);
            start <= 1'b0;
            @(negedge clock);
            check_value($sformatf("busy (vector %0d)", num), busy, 1);
        end
        wait_for_done(limit);
        check_value($sformatf("busy (vector %0d)", num), busy, 0);
        check_value($sformatf("ack_error (vector %0d)", num), ack_error, exp_err);
        check_value($sformatf("read_data (vector %0d)", num), read_data, exp_rd);
        check_quiet(20);
    endtask

    initial begin
        int          fd;
        int          fields;
        int          vectors_run;
        string       line;
        byte         kind;
        logic [31:0] dev;
        logic [31:0] reg_addr;
        logic [31:0] wdata;
        logic [31:0] div;
        logic [31:0] stretch;
        logic [31:0] exp_rd;
        logic [31:0] exp_err;

        clock            = 1'b0;
        reset_n          = 1'b0;
        start            = 1'b0;
        read_write       = 1'b0;
        device_address   = '0;
        register_address = '0;
        write_data       = '0;
        divider          = '0;
        stretch_cycles   = '0;
        vectors_run      = 0;

        repeat (5) @(posedge clock);
        reset_n <= 1'b1;

        fd = $fopen("tests/i2c_master_vectors.txt", "r");
        if (fd == 0) begin
            stop_on_failure("could not open tests/i2c_master_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            kind = line[0];
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %d %h %h",
                             dev, reg_addr, wdata, div, stretch, exp_rd, exp_err);
            if (fields != 7) begin
                stop_on_failure($sformatf("malformed vector line: %s", line));
            end
            vectors_run++;
            run_vector(vectors_run, kind, dev, reg_addr, wdata, div, stretch,
                       exp_rd, exp_err);
        end
        $fclose(fd);

        if (vectors_run == 0 || DUT.u_checker.failures != 0) begin
            stop_on_failure($sformatf("%0d vectors run, %0d assertion failures",
                                      vectors_run, DUT.u_checker.failures));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/i2c_master_vectors.txt
# kind dev reg wdata divider stretch read_data ack_error (hex, stretch in decimal clocks)
# kind W write, R read, D write with a second start while busy
# divider never decreases, the tick counter restarts only on an exact match
R 50 20 00 0000 0 00 0
W 50 11 3c 0000 0 00 0
R 50 11 00 0000 0 3c 0
W 50 ff 01 0000 3 3c 0
R 50 ff 00 0000 2 01 0
D 50 14 77 0001 0 01 0
R 50 14 00 0001 0 77 0
R 2a 14 00 0001 0 77 1
R 50 80 00 0002 0 00 0
W 50 13 5a 0002 5 00 0
R 50 13 00 0002 9 5a 0
W 50 10 a5 0003 0 5a 0
W 51 10 ff 0003 0 5a 1
R 50 10 00 0003 0 a5 0
W 50 12 c3 0007 4 a5 0
R 50 12 00 0007 0 c3 0
R 50 11 00 0007 1 3c 0

//--- tests/i2c_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model #(
    parameter i2c_pkg::dev_addr_t address = 7'h50
) (
    input  wire        clock,
    input  wire [15:0] stretch_cycles,
    inout  wire        sda,
    inout  wire        scl
);

    import i2c_pkg::*;

    typedef enum {
        m_idle,
        m_address,
        m_register,
        m_write,
        m_transmit,
        m_ignore
    } slave_mode_t;

    byte_t       mem [256];
    slave_mode_t mode = m_idle;
    byte_t       shift = '0;
    byte_t       tx_data = '0;
    byte_t       pointer = '0;
    logic        reading = 1'b0;
    int          bit_cnt = 0;
    logic [15:0] hold_count = '0;
    logic        scl_q = 1'b1;
    logic        sda_q = 1'b1;
    logic        sda_drive = 1'b0;
    logic        scl_drive = 1'b0;

    assign sda = sda_drive ? 1'b0 : 1'bz;
    assign scl = scl_drive ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
    end

    // bus oversampled on the system clock
    always @(posedge clock) begin
        logic ack_now;
        ack_now = 1'b0;
        scl_q <= scl;
        sda_q <= sda;
        if (hold_count == 16'd1) begin
            scl_drive <= 1'b0;
        end
        if (hold_count != '0) begin
            hold_count <= hold_count - 16'd1;
        end
        if (scl && scl_q && sda_q && !sda) begin
            // start or repeated start
            mode      <= m_address;
            bit_cnt   <= 0;
            sda_drive <= 1'b0;
        end else if (scl && scl_q && !sda_q && sda) begin
            mode      <= m_idle;
            sda_drive <= 1'b0;
        end else if (scl && !scl_q && mode != m_idle) begin
            if (bit_cnt < 8) begin
                shift <= {shift[6:0], sda};
            end
            bit_cnt <= bit_cnt + 1;
        end else if (!scl && scl_q && mode != m_idle) begin
            if (bit_cnt == 8) begin
                case (mode)
                    m_address: begin
                        if (shift[7:1] == address) begin
                            ack_now = 1'b1;
                            reading <= (shift[0] == read_bit);
                        end else begin
                            mode <= m_ignore;
                        end
                    end
                    m_register: begin
                        pointer <= shift;
                        ack_now = 1'b1;
                    end
                    m_write: begin
                        mem[pointer] <= shift;
                        ack_now = 1'b1;
                    end
                    // master owns the acknowledge slot
                    default: sda_drive <= 1'b0;
                endcase
            end else if (bit_cnt == 9) begin
                bit_cnt   <= 0;
                sda_drive <= 1'b0;
                case (mode)
                    m_address: begin
                        if (reading) begin
                            mode      <= m_transmit;
                            tx_data   <= mem[pointer];
                            sda_drive <= ~mem[pointer][7];
                        end else begin
                            mode <= m_register;
                        end
                    end
                    m_register: mode <= m_write;
                    m_transmit: mode <= m_ignore;
                    default: begin
                    end
                endcase
            end else if (mode == m_transmit) begin
                sda_drive <= ~tx_data[7 - bit_cnt];
            end
        end
        // ack, and stretch the clock while it is held
        if (ack_now) begin
            sda_drive <= 1'b1;
            if (stretch_cycles != '0) begin
                scl_drive  <= 1'b1;
                hold_count <= stretch_cycles;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/i2c_pkg.sv
logic/i2c_tick_divider.sv
logic/i2c_bit_engine.sv
logic/i2c_byte_engine.sv
logic/i2c_transaction_sequencer.sv
logic/i2c_master.sv
tests/i2c_master_checker.sv
tests/i2c_slave_model.sv
tests/i2c_master_tb.sv
